// ==== Makefile ====
TOP := wts_mixer_tb
SRCS := $(wildcard hw/*.sv hw/*.svh bench/*.sv)

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f wts_mixer.f --top-module $(TOP)

obj_dir/V$(TOP): wts_mixer.f $(SRCS)
	verilator --binary --timing --assert -f wts_mixer.f --top-module $(TOP)

sim: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) > sim.log 2>&1 || (cat sim.log; exit 1)
	cat sim.log
	! grep -q "Verification failed" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== bench/wts_mixer_tb.sv ====
// outputs are checked 64 cycles after every change; only one CPU wave access is in flight at a time
`timescale 1ns/10ps
`include "wts_macros.svh"

module wts_mixer_tb;

	localparam int CLK_PERIOD = 40;
	localparam int SETTLE_CYCLES = 64;
	localparam int WAVE_LEN = 1 << `WTS_POS_W;
	localparam int ALL_SAMPLES = `WTS_VOICES * WAVE_LEN;
	localparam int ROUNDS = 4;
	// worst case cycles for one write, one read and one settled output check
	localparam int WRITE_CYCLES = 5;
	localparam int READ_CYCLES = 9;
	localparam int CHECK_CYCLES = SETTLE_CYCLES + 6;
	localparam int TEST_CYCLES = 10 + 2 * CHECK_CYCLES
		+ ALL_SAMPLES * (2 * WRITE_CYCLES + READ_CYCLES)
		+ ROUNDS * CHECK_CYCLES + WAVE_LEN * WRITE_CYCLES + 6 * CHECK_CYCLES;
	localparam int MARGIN_CYCLES = 500;
	localparam logic [`WTS_SAMPLE_W-1:0] FIRST_SAMPLE = 8'h70;
	localparam logic [`WTS_SAMPLE_W-1:0] OTHER_SAMPLE = 8'hc0;

	logic											clk;
	logic											nreset;
	logic	[`WTS_VOICES-1:0]						key_on;
	logic	[`WTS_VOICES-1:0]						key_off;
	wts_pkg::wave_id_t								wave_id;
	logic	[`WTS_POS_W-1:0]						wave_a;
	logic	[`WTS_SAMPLE_W-1:0]						wave_d;
	logic											wave_oe;
	logic											wave_we;
	logic	[`WTS_SAMPLE_W-1:0]						wave_q;
	logic											wave_q_en;
	logic	[`WTS_VOICES-1:0][`WTS_VOL_W-1:0]		volume;
	logic	[`WTS_VOICES-1:0][1:0]					enable;
	logic	[`WTS_VOICES-1:0][`WTS_FREQ_W-1:0]		frequency_count;
	logic	[`WTS_OUT_W-1:0]						left_out;
	logic	[`WTS_OUT_W-1:0]						right_out;

	logic	[31:0]									lfsr_state;
	logic	[`WTS_SAMPLE_W-1:0]						wave_mem	[`WTS_VOICES][WAVE_LEN];
	logic	[`WTS_VOICES-1:0][`WTS_SAMPLE_W-1:0]	sounding;
	logic	[`WTS_VOICES-1:0]						voice_muted;
	logic	[`WTS_OUT_W-1:0]						exp_left;
	logic	[`WTS_OUT_W-1:0]						exp_right;
	logic											check_req;
	int												check_count;
	int												cmp_errors;
	int												stim_errors;
	int												tests_run;
	int												tests_passed;
	int												errors_at_start;

	initial clk = 1'b0;
	always #(CLK_PERIOD / 2) clk = ~clk;

	wts_mixer_top uut (
		.clk				(clk),
		.nreset				(nreset),
		.key_on				(key_on),
		.key_off			(key_off),
		.wave_id			(wave_id),
		.wave_a				(wave_a),
		.wave_d				(wave_d),
		.wave_oe			(wave_oe),
		.wave_we			(wave_we),
		.wave_q				(wave_q),
		.wave_q_en			(wave_q_en),
		.volume				(volume),
		.enable				(enable),
		.frequency_count	(frequency_count),
		.left_out			(left_out),
		.right_out			(right_out)
	);

	// ----------------------------------------------------------
	// random source and reference model
	// ----------------------------------------------------------
	// galois form of x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		if (s[0]) begin
			return (s >> 1) ^ 32'h80200003;
		end
		return s >> 1;
	endfunction

	task automatic take_bits(input int n, output logic [31:0] value);
		value = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_step(lfsr_state);
			value = {value[30:0], lfsr_state[0]};
		end
	endtask

	// each voice adds floor(sample * volume / 16) to the sides it is enabled on
	function automatic logic [2*`WTS_OUT_W-1:0] mix_reference(
			input logic [`WTS_VOICES-1:0][`WTS_SAMPLE_W-1:0] smp,
			input logic [`WTS_VOICES-1:0][`WTS_VOL_W-1:0] vol,
			input logic [`WTS_VOICES-1:0][1:0] en,
			input logic [`WTS_VOICES-1:0] mt);
		int						left_sum;
		int						right_sum;
		int						part;
		logic	[`WTS_OUT_W-1:0]	left_code;
		logic	[`WTS_OUT_W-1:0]	right_code;
		left_sum = 0;
		right_sum = 0;
		for (int v = 0; v < `WTS_VOICES; v++) begin
			if (!mt[v]) begin
				part = int'($signed(smp[v])) * int'(vol[v]);
				part = part >>> 4;
				if (en[v][1]) begin
					left_sum += part;
				end
				if (en[v][0]) begin
					right_sum += part;
				end
			end
		end
		// wrap to 12 bits, then flip the MSB for offset binary
		left_code = 12'(left_sum) ^ 12'h800;
		right_code = 12'(right_sum) ^ 12'h800;
		return {left_code, right_code};
	endfunction

	// ----------------------------------------------------------
	// stimulus helpers
	// ----------------------------------------------------------
	task automatic write_sample(input int voice, input int pos, input logic [7:0] data);
		@(posedge clk);
		wave_id.number <= voice[2:0];
		wave_a <= pos[`WTS_POS_W-1:0];
		wave_d <= data;
		wave_we <= 1'b1;
		@(posedge clk);
		wave_we <= 1'b0;
		repeat (3) begin
			@(negedge clk);
			if (wave_q_en) begin
				$display("write to voice %0d sample %0d raised wave_q_en", voice, pos);
				stim_errors++;
			end
		end
	endtask

	task automatic read_sample(input int voice, input int pos, output logic [7:0] q,
			output int latency, output int pulses);
		@(posedge clk);
		wave_id.number <= voice[2:0];
		wave_a <= pos[`WTS_POS_W-1:0];
		wave_oe <= 1'b1;
		@(posedge clk);
		wave_oe <= 1'b0;
		latency = 1;
		pulses = 0;
		q = 'x;
		while (pulses == 0 && latency <= 6) begin
			@(negedge clk);
			if (wave_q_en) begin
				pulses = 1;
				q = wave_q;
			end else begin
				@(posedge clk);
				latency++;
			end
		end
		// the pulse must be gone one cycle later
		@(negedge clk);
		if (wave_q_en) begin
			pulses++;
		end
	endtask

	task automatic pulse_keys(input logic [`WTS_VOICES-1:0] on_mask,
			input logic [`WTS_VOICES-1:0] off_mask);
		@(posedge clk);
		key_on <= on_mask;
		key_off <= off_mask;
		@(posedge clk);
		key_on <= '0;
		key_off <= '0;
		voice_muted = (voice_muted | off_mask) & ~on_mask;
	endtask

	task automatic settle_and_check();
		repeat (SETTLE_CYCLES) @(posedge clk);
		{exp_left, exp_right} = mix_reference(sounding, volume, enable, voice_muted);
		@(posedge clk);
		check_req <= 1'b1;
		@(posedge clk);
		check_req <= 1'b0;
	endtask

	task automatic report_test(input string name);
		int errors;
		errors = cmp_errors + stim_errors - errors_at_start;
		tests_run++;
		if (errors == 0) begin
			tests_passed++;
			$display("test %0d %s: ok", tests_run, name);
		end else begin
			$display("test %0d %s: %0d errors", tests_run, name, errors);
		end
		errors_at_start = cmp_errors + stim_errors;
	endtask

	// ----------------------------------------------------------
	// output compare and watchdog
	// ----------------------------------------------------------
	always @(negedge clk) begin
		if (check_req) begin
			check_count++;
			if (left_out !== exp_left) begin
				$display("[FAIL] %0t left_out expected %h got %h", $time, exp_left, left_out);
				cmp_errors++;
			end
			if (right_out !== exp_right) begin
				$display("[FAIL] %0t right_out expected %h got %h", $time, exp_right, right_out);
				cmp_errors++;
			end
		end
	end

	initial begin
		#((TEST_CYCLES + MARGIN_CYCLES) * CLK_PERIOD);
		$display("run did not finish within %0d cycles", TEST_CYCLES + MARGIN_CYCLES);
		$display("Verification failed");
		$finish;
	end

	// ----------------------------------------------------------
	// test sequence
	// ----------------------------------------------------------
	initial begin
		logic	[31:0]					bits;
		logic	[`WTS_SAMPLE_W-1:0]		q;
		logic	[`WTS_VOICES-1:0]		off_mask;
		int								latency;
		int								pulses;
		lfsr_state = 32'hdcc3cf87;
		nreset <= 1'b0;
		key_on <= '0;
		key_off <= '0;
		wave_id <= '0;
		wave_a <= '0;
		wave_d <= '0;
		wave_oe <= 1'b0;
		wave_we <= 1'b0;
		volume <= '0;
		enable <= '0;
		frequency_count <= '0;
		check_req <= 1'b0;
		voice_muted = '1;
		sounding = '0;
		check_count = 0;
		cmp_errors = 0;
		stim_errors = 0;
		tests_run = 0;
		tests_passed = 0;
		errors_at_start = 0;
		repeat (10) @(posedge clk);
		// the output registers still hold their reset value in the first cycle after release
		exp_left = 12'h800;
		exp_right = 12'h800;
		nreset <= 1'b1;
		check_req <= 1'b1;
		@(posedge clk);
		check_req <= 1'b0;

		for (int i = 0; i < SETTLE_CYCLES; i++) begin
			@(negedge clk);
			if (wave_q_en) begin
				$display("wave_q_en went high after reset with no access");
				stim_errors++;
			end
		end
		settle_and_check();
		report_test("reset state");

		for (int v = 0; v < `WTS_VOICES; v++) begin
			for (int a = 0; a < WAVE_LEN; a++) begin
				take_bits(`WTS_SAMPLE_W, bits);
				wave_mem[v][a] = bits[`WTS_SAMPLE_W-1:0];
				write_sample(v, a, wave_mem[v][a]);
			end
		end
		for (int v = 0; v < `WTS_VOICES; v++) begin
			for (int a = 0; a < WAVE_LEN; a++) begin
				read_sample(v, a, q, latency, pulses);
				if (pulses != 1) begin
					$display("read of voice %0d sample %0d gave %0d wave_q_en pulses", v, a, pulses);
					stim_errors++;
				end else if (latency < 2 || latency > 3) begin
					$display("wave_q_en came %0d cycles after the strobe", latency);
					stim_errors++;
				end else if (q !== wave_mem[v][a]) begin
					$display("[FAIL] %0t wave_q expected %h got %h", $time, wave_mem[v][a], q);
					stim_errors++;
				end
			end
		end
		report_test("wave RAM readback");

		// constant waves make the output independent of the wave position
		for (int v = 0; v < `WTS_VOICES; v++) begin
			take_bits(`WTS_SAMPLE_W, bits);
			sounding[v] = bits[`WTS_SAMPLE_W-1:0];
			for (int a = 0; a < WAVE_LEN; a++) begin
				write_sample(v, a, sounding[v]);
			end
		end
		pulse_keys('1, '0);
		for (int r = 0; r < ROUNDS; r++) begin
			@(posedge clk);
			for (int v = 0; v < `WTS_VOICES; v++) begin
				take_bits(`WTS_VOL_W, bits);
				volume[v] <= bits[`WTS_VOL_W-1:0];
				take_bits(2, bits);
				enable[v] <= bits[1:0];
				take_bits(4, bits);
				frequency_count[v] <= `WTS_FREQ_W'(bits[3:0]);
			end
			settle_and_check();
		end
		report_test("random volume and stereo enable");

		pulse_keys('0, '1);
		@(posedge clk);
		frequency_count[0] <= '0;
		volume[0] <= '1;
		enable[0] <= 2'b11;
		write_sample(0, 0, FIRST_SAMPLE);
		for (int a = 1; a < WAVE_LEN; a++) begin
			write_sample(0, a, OTHER_SAMPLE);
		end
		sounding[0] = FIRST_SAMPLE;
		pulse_keys(6'b000001, '0);
		settle_and_check();
		settle_and_check();
		@(posedge clk);
		frequency_count[0] <= 12'd1;
		sounding[0] = OTHER_SAMPLE;
		settle_and_check();
		report_test("key_on to sample 0 and stepping");

		@(posedge clk);
		frequency_count[0] <= '0;
		for (int v = 0; v < `WTS_VOICES; v++) begin
			take_bits(`WTS_VOL_W, bits);
			volume[v] <= bits[`WTS_VOL_W-1:0] | 4'h8;
			enable[v] <= 2'b11;
		end
		sounding[0] = FIRST_SAMPLE;
		pulse_keys('1, '0);
		settle_and_check();
		take_bits(`WTS_VOICES, bits);
		off_mask = bits[`WTS_VOICES-1:0] | 6'b000010;
		pulse_keys('0, off_mask);
		settle_and_check();
		pulse_keys(off_mask, '0);
		settle_and_check();
		report_test("key_off and key_on per voice");

		$display("tests passed: %0d of %0d, output checks: %0d, errors: %0d",
			tests_passed, tests_run, check_count, cmp_errors + stim_errors);
		if (cmp_errors + stim_errors == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

// ==== hw/wts_macros.svh ====
// fixed build of six voices with 32-sample waves of 8 bits; other voice counts are not supported
`ifndef WTS_MACROS_SVH
`define WTS_MACROS_SVH

// ----------------------------------------------------------
// voice and wave geometry
// ----------------------------------------------------------
`define WTS_VOICES 6
`define WTS_SAMPLE_W 8
`define WTS_POS_W 5

// bank address is the voice pair followed by the sample position
`define WTS_RAM_AW 7

// ----------------------------------------------------------
// per-voice controls
// ----------------------------------------------------------
`define WTS_FREQ_W 12
`define WTS_VOL_W 4

// ----------------------------------------------------------
// output
// ----------------------------------------------------------
`define WTS_OUT_W 12
// offset-binary zero
`define WTS_OUT_RESET 12'h800

`endif

// ==== hw/wts_mixer_top.sv ====
// six voices share one datapath; wait for wave_q_en, or 3 cycles after a write, before a new strobe
`timescale 1ns/10ps
`include "wts_macros.svh"

module wts_mixer_top (
	input	logic											clk,
	input	logic											nreset,
	input	logic	[`WTS_VOICES-1:0]						key_on,
	input	logic	[`WTS_VOICES-1:0]						key_off,
	input	wts_pkg::wave_id_t								wave_id,
	input	logic	[`WTS_POS_W-1:0]						wave_a,
	input	logic	[`WTS_SAMPLE_W-1:0]						wave_d,
	input	logic											wave_oe,
	input	logic											wave_we,
	output	logic	[`WTS_SAMPLE_W-1:0]						wave_q,
	output	logic											wave_q_en,
	input	logic	[`WTS_VOICES-1:0][`WTS_VOL_W-1:0]		volume,
	input	logic	[`WTS_VOICES-1:0][1:0]					enable,
	input	logic	[`WTS_VOICES-1:0][`WTS_FREQ_W-1:0]		frequency_count,
	output	logic	[`WTS_OUT_W-1:0]						left_out,
	output	logic	[`WTS_OUT_W-1:0]						right_out
);

	logic									w_frame_last;
	logic									w_mute;
	logic	signed	[`WTS_SAMPLE_W-1:0]		w_left_part;
	logic	signed	[`WTS_SAMPLE_W-1:0]		w_right_part;

	wts_ram_if u_ram_if ();

	wts_slot_sequencer u_sequencer (
		.clk			(clk),
		.nreset			(nreset),
		.wave_id		(wave_id),
		.wave_a			(wave_a),
		.wave_d			(wave_d),
		.wave_oe		(wave_oe),
		.wave_we		(wave_we),
		.wave_q			(wave_q),
		.wave_q_en		(wave_q_en),
		.frame_last		(w_frame_last),
		.ram			(u_ram_if.seq)
	);

	wts_tone_generator u_tone (
		.clk				(clk),
		.nreset				(nreset),
		.key_on				(key_on),
		.key_off			(key_off),
		.frequency_count	(frequency_count),
		.mute				(w_mute),
		.ram				(u_ram_if.tone)
	);

	wts_wave_ram u_wave_ram (
		.clk			(clk),
		.ram			(u_ram_if.ram)
	);

	wts_voice_scaler u_scaler (
		.clk			(clk),
		.nreset			(nreset),
		.volume			(volume),
		.enable			(enable),
		.mute			(w_mute),
		.left_part		(w_left_part),
		.right_part		(w_right_part),
		.ram			(u_ram_if.tap)
	);

	wts_stereo_mixer u_mixer (
		.clk			(clk),
		.nreset			(nreset),
		.frame_last		(w_frame_last),
		.left_part		(w_left_part),
		.right_part		(w_right_part),
		.left_out		(left_out),
		.right_out		(right_out)
	);

endmodule

// ==== hw/wts_pkg.sv ====
// wave ids 6 and 7 have no storage behind them and must not be used
package wts_pkg;

	// the low bit of a voice number picks the RAM bank, the rest picks the pair
	typedef struct packed {
		logic	[1:0]	pair;
		logic			bank;
	} wave_sel_t;

	// one word, seen either as voice number 0 to 5 or as pair and bank
	typedef union packed {
		logic	[2:0]	number;
		wave_sel_t		sel;
	} wave_id_t;

endpackage

// ==== hw/wts_ram_if.sv ====
// slot values above 5 never occur; cpu fields are only meaningful while cpu_en is high
`timescale 1ns/10ps
`include "wts_macros.svh"

interface wts_ram_if;

	// current slot of the six-slot ring
	logic	[2:0]					slot;

	// CPU side, one granted access at a time
	logic							cpu_en;
	logic							cpu_we;
	logic	[`WTS_RAM_AW-1:0]		cpu_addr;
	logic							cpu_bank;
	logic	[`WTS_SAMPLE_W-1:0]		cpu_d;
	logic	[`WTS_SAMPLE_W-1:0]		cpu_q;

	// sound side, bank given by the slot parity
	logic	[`WTS_RAM_AW-1:0]		sound_addr;
	logic	[`WTS_SAMPLE_W-1:0]		sound_q;

	modport seq (output slot, cpu_en, cpu_we, cpu_addr, cpu_bank, cpu_d, input cpu_q);
	modport tone (input slot, output sound_addr);
	modport ram (
		input	slot, cpu_en, cpu_we, cpu_addr, cpu_bank, cpu_d, sound_addr,
		output	sound_q, cpu_q
	);
	modport tap (input slot, sound_q);

endinterface

// ==== hw/wts_slot_sequencer.sv ====
// one CPU access may be pending at a time; a new strobe before wave_q_en or the write slot is lost
`timescale 1ns/10ps
`include "wts_macros.svh"

module wts_slot_sequencer (
	input	logic							clk,
	input	logic							nreset,
	input	wts_pkg::wave_id_t				wave_id,
	input	logic	[`WTS_POS_W-1:0]		wave_a,
	input	logic	[`WTS_SAMPLE_W-1:0]		wave_d,
	input	logic							wave_oe,
	input	logic							wave_we,
	output	logic	[`WTS_SAMPLE_W-1:0]		wave_q,
	output	logic							wave_q_en,
	output	logic							frame_last,
	wts_ram_if.seq							ram
);

	logic	[2:0]					ff_slot;
	logic							ff_pend;
	logic							ff_we;
	wts_pkg::wave_id_t				ff_id;
	logic	[`WTS_POS_W-1:0]		ff_a;
	logic	[`WTS_SAMPLE_W-1:0]		ff_d;
	logic							ff_q_en;
	logic							w_grant;

	// ----------------------------------------------------------
	// slot ring
	// ----------------------------------------------------------
	always_ff @(posedge clk) begin
		if (!nreset) begin
			ff_slot <= 3'd0;
		end else if (ff_slot == 3'(`WTS_VOICES - 1)) begin
			ff_slot <= 3'd0;
		end else begin
			ff_slot <= ff_slot + 3'd1;
		end
	end

	// voice 5 is addressed in slot 5 and its contribution lands two slots later
	assign frame_last = (ff_slot == 3'd1);

	// ----------------------------------------------------------
	// CPU wave access
	// ----------------------------------------------------------
	always_ff @(posedge clk) begin
		if (!nreset) begin
			ff_pend <= 1'b0;
		end else if (wave_oe || wave_we) begin
			ff_pend <= 1'b1;
		end else if (w_grant) begin
			ff_pend <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (wave_oe || wave_we) begin
			ff_id <= wave_id;
			ff_a <= wave_a;
			ff_d <= wave_d;
			ff_we <= wave_we;
		end
	end

	// the sound side owns the bank that matches the slot parity
	assign w_grant = ff_pend && (ff_slot[0] != ff_id.sel.bank);

	always_ff @(posedge clk) begin
		if (!nreset) begin
			ff_q_en <= 1'b0;
		end else begin
			ff_q_en <= w_grant && !ff_we;
		end
	end

	assign ram.slot = ff_slot;
	assign ram.cpu_en = w_grant;
	assign ram.cpu_we = ff_we;
	assign ram.cpu_addr = {ff_id.sel.pair, ff_a};
	assign ram.cpu_bank = ff_id.sel.bank;
	assign ram.cpu_d = ff_d;

	assign wave_q = ram.cpu_q;
	assign wave_q_en = ff_q_en;

	a_strobe_while_pending: assert property (@(posedge clk) disable iff (!nreset)
		(wave_oe || wave_we) |-> !ff_pend);

	a_q_en_single: assert property (@(posedge clk) disable iff (!nreset)
		wave_q_en |=> !wave_q_en);

endmodule

// ==== hw/wts_stereo_mixer.sv ====
// sums wrap modulo 4096; outputs are offset binary and change once per frame
`timescale 1ns/10ps
`include "wts_macros.svh"

module wts_stereo_mixer (
	input	logic								clk,
	input	logic								nreset,
	input	logic								frame_last,
	input	logic	signed	[`WTS_SAMPLE_W-1:0]	left_part,
	input	logic	signed	[`WTS_SAMPLE_W-1:0]	right_part,
	output	logic	[`WTS_OUT_W-1:0]			left_out,
	output	logic	[`WTS_OUT_W-1:0]			right_out
);

	localparam int EXT_W = `WTS_OUT_W - `WTS_SAMPLE_W;

	logic	[`WTS_SAMPLE_W-1:0]		w_part	[2];
	logic	[`WTS_OUT_W-1:0]		w_total	[2];
	logic	[`WTS_OUT_W-1:0]		ff_sum	[2];
	logic	[`WTS_OUT_W-1:0]		ff_out	[2];

	// side 0 is left, side 1 is right
	assign w_part[0] = left_part;
	assign w_part[1] = right_part;

	always_comb begin
		for (int s = 0; s < 2; s++) begin
			w_total[s] = ff_sum[s] + {{EXT_W{w_part[s][`WTS_SAMPLE_W-1]}}, w_part[s]};
		end
	end

	always_ff @(posedge clk) begin
		if (!nreset) begin
			for (int s = 0; s < 2; s++) begin
				ff_sum[s] <= '0;
				ff_out[s] <= `WTS_OUT_RESET;
			end
		end else begin
			for (int s = 0; s < 2; s++) begin
				if (frame_last) begin
					ff_sum[s] <= '0;
					ff_out[s] <= {~w_total[s][`WTS_OUT_W-1], w_total[s][`WTS_OUT_W-2:0]};
				end else begin
					ff_sum[s] <= w_total[s];
				end
			end
		end
	end

	assign left_out = ff_out[0];
	assign right_out = ff_out[1];

endmodule

// ==== hw/wts_tone_generator.sv ====
// key_on wins over key_off in the same cycle; frequency_count 0 freezes the position
`timescale 1ns/10ps
`include "wts_macros.svh"

module wts_tone_generator (
	input	logic											clk,
	input	logic											nreset,
	input	logic	[`WTS_VOICES-1:0]						key_on,
	input	logic	[`WTS_VOICES-1:0]						key_off,
	input	logic	[`WTS_VOICES-1:0][`WTS_FREQ_W-1:0]		frequency_count,
	output	logic											mute,
	wts_ram_if.tone											ram
);

	logic	[`WTS_FREQ_W-1:0]		ff_divider	[`WTS_VOICES];
	logic	[`WTS_POS_W-1:0]		ff_position	[`WTS_VOICES];
	logic	[`WTS_VOICES-1:0]		ff_muted;
	logic							ff_mute;
	wts_pkg::wave_id_t				w_voice;

	assign w_voice = wts_pkg::wave_id_t'(ram.slot);

	// ----------------------------------------------------------
	// per-voice divider, position and key state
	// ----------------------------------------------------------
	always_ff @(posedge clk) begin
		if (!nreset) begin
			ff_muted <= '1;
			for (int v = 0; v < `WTS_VOICES; v++) begin
				ff_divider[v] <= '0;
				ff_position[v] <= '0;
			end
		end else begin
			for (int v = 0; v < `WTS_VOICES; v++) begin
				if (key_on[v]) begin
					ff_position[v] <= '0;
					ff_divider[v] <= frequency_count[v];
					ff_muted[v] <= 1'b0;
				end else begin
					if (key_off[v]) begin
						ff_muted[v] <= 1'b1;
					end
					// each divider steps once per frame, in its own slot
					if (ram.slot == 3'(v) && frequency_count[v] != '0) begin
						if (ff_divider[v] == '0) begin
							ff_divider[v] <= frequency_count[v];
							ff_position[v] <= ff_position[v] + 1'b1;
						end else begin
							ff_divider[v] <= ff_divider[v] - 1'b1;
						end
					end
				end
			end
		end
	end

	// mute follows the RAM read by one cycle so it lines up with sound_q
	always_ff @(posedge clk) begin
		if (!nreset) begin
			ff_mute <= 1'b1;
		end else begin
			ff_mute <= ff_muted[ram.slot];
		end
	end

	assign ram.sound_addr = {w_voice.sel.pair, ff_position[ram.slot]};
	assign mute = ff_mute;

endmodule

// ==== hw/wts_voice_scaler.sv ====
// envelope is fixed at full scale; samples are two's complement and volume is unsigned
`timescale 1ns/10ps
`include "wts_macros.svh"

module wts_voice_scaler (
	input	logic											clk,
	input	logic											nreset,
	input	logic	[`WTS_VOICES-1:0][`WTS_VOL_W-1:0]		volume,
	input	logic	[`WTS_VOICES-1:0][1:0]					enable,
	input	logic											mute,
	output	logic	signed	[`WTS_SAMPLE_W-1:0]				left_part,
	output	logic	signed	[`WTS_SAMPLE_W-1:0]				right_part,
	wts_ram_if.tap											ram
);

	logic	[2:0]										w_voice;
	logic	signed	[`WTS_SAMPLE_W+`WTS_VOL_W:0]		w_product;
	logic	signed	[`WTS_SAMPLE_W-1:0]				w_scaled;

	// sound_q belongs to the voice of the previous slot
	assign w_voice = (ram.slot == 3'd0) ? 3'(`WTS_VOICES - 1) : ram.slot - 3'd1;

	assign w_product = $signed(ram.sound_q) * $signed({1'b0, volume[w_voice]});

	// the product fits in 12 bits, so dropping the low 4 keeps the sign
	assign w_scaled = w_product[`WTS_SAMPLE_W+`WTS_VOL_W-1:`WTS_VOL_W];

	// ----------------------------------------------------------
	// stereo enable, bit 1 left and bit 0 right
	// ----------------------------------------------------------
	always_ff @(posedge clk) begin
		if (!nreset) begin
			left_part <= '0;
			right_part <= '0;
		end else begin
			left_part <= (!mute && enable[w_voice][1]) ? w_scaled : '0;
			right_part <= (!mute && enable[w_voice][0]) ? w_scaled : '0;
		end
	end

endmodule

// ==== hw/wts_wave_ram.sv ====
// contents are undefined until written; addresses of pair 3 are outside both banks
`timescale 1ns/10ps
`include "wts_macros.svh"

module wts_wave_ram (
	input	logic		clk,
	wts_ram_if.ram		ram
);

	localparam int DEPTH = (`WTS_VOICES / 2) << `WTS_POS_W;

	logic	ff_sound_bank;

	// each bank is single ported and shared between the two sides by slot parity
	for (genvar b = 0; b < 2; b++) begin : g_bank
		logic	[`WTS_SAMPLE_W-1:0]		mem	[DEPTH];
		logic	[`WTS_SAMPLE_W-1:0]		ff_rd;
		logic	[`WTS_RAM_AW-1:0]		w_addr;
		logic							w_we;

		assign w_addr = (ram.slot[0] == 1'(b)) ? ram.sound_addr : ram.cpu_addr;
		assign w_we = ram.cpu_en && ram.cpu_we && (ram.cpu_bank == 1'(b));

		always_ff @(posedge clk) begin
			if (w_we) begin
				mem[w_addr] <= ram.cpu_d;
			end
			ff_rd <= mem[w_addr];
		end
	end

	always_ff @(posedge clk) begin
		ff_sound_bank <= ram.slot[0];
	end

	assign ram.sound_q = ff_sound_bank ? g_bank[1].ff_rd : g_bank[0].ff_rd;
	assign ram.cpu_q = ff_sound_bank ? g_bank[0].ff_rd : g_bank[1].ff_rd;

	a_bank_conflict: assert property (@(posedge clk)
		ram.cpu_en |-> (ram.cpu_bank != ram.slot[0]));

endmodule

// ==== wts_mixer.f ====
+incdir+hw
hw/wts_pkg.sv
hw/wts_ram_if.sv
hw/wts_slot_sequencer.sv
hw/wts_tone_generator.sv
hw/wts_wave_ram.sv
hw/wts_voice_scaler.sv
hw/wts_stereo_mixer.sv
hw/wts_mixer_top.sv
bench/wts_mixer_tb.sv
